// File: hw/qos_cache_pkg.sv
// ------------------------------
// QoS cache shared definitions
// Widths, request and response structs, replacement
// policy encoding and performance counter layout
// ------------------------------
package qos_cache_pkg;

    typedef logic [31:0] addr_t;       // Byte address
    typedef logic [31:0] word_t;       // Data word
    typedef logic [1:0]  qos_level_t;  // 0 low .. 3 critical
    typedef logic [7:0]  stamp_t;      // Cycle timer value, wraps
    typedef logic [15:0] count_t;      // Saturating perf count

    // Per-request QoS attributes, 11 bits
    typedef struct packed {
        qos_level_t level;
        logic       urgent;       // Beats any level
        logic [7:0] max_latency;  // Cycles, request to response
    } qos_cfg_t;

    typedef struct packed {
        addr_t    addr;
        qos_cfg_t qos;
    } cache_req_t;

    // Queue slot payload
    typedef struct packed {
        cache_req_t req;
        stamp_t     arrival;  // Timer value at push
    } queue_entry_t;

    typedef struct packed {
        word_t    data;
        logic     hit;
        qos_cfg_t qos;  // Echo of the request
    } cache_rsp_t;

    // Encoding 3 falls back to plain LRU
    typedef enum logic [1:0] {
        REPL_LRU          = 2'd0,
        REPL_QOS_LRU      = 2'd1,
        REPL_QOS_PRIORITY = 2'd2
    } repl_policy_e;

    typedef struct packed {
        count_t [3:0] hits;    // Indexed by level
        count_t [3:0] misses;  // Indexed by level
        count_t       violations;
    } perf_counts_t;

endpackage

// File: hw/qos_req_queue.sv
// ------------------------------
// Request queue with QoS selection
// Holds pending requests with arrival stamps and offers
// the best one: urgent, then level, then oldest
// ------------------------------
module qos_req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        push_i,
    input  qos_cache_pkg::cache_req_t   push_req_i,
    input  qos_cache_pkg::stamp_t       now_i,
    input  logic                        deq_i,
    output logic                        sel_valid_o,
    output qos_cache_pkg::queue_entry_t sel_entry_o
);
    localparam int SLOT_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    qos_cache_pkg::queue_entry_t slot_q [QUEUE_DEPTH];  // Payload, no reset
    logic [QUEUE_DEPTH-1:0]      valid_q;
    logic [SLOT_W-1:0]           free_idx;
    logic [SLOT_W-1:0]           sel_idx;
    logic                        free_found;

    // Lowest free slot for the next push
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (!valid_q[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = SLOT_W'(i);
            end
        end
    end

    // ------------------------------
    // Priority pick
    // ------------------------------
    always_comb begin
        qos_cache_pkg::qos_cfg_t best_qos;
        qos_cache_pkg::stamp_t   best_age;
        qos_cache_pkg::qos_cfg_t cur_qos;
        qos_cache_pkg::stamp_t   cur_age;
        logic                    better;
        sel_valid_o = 1'b0;
        sel_idx     = '0;
        best_qos    = '0;
        best_age    = '0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            cur_qos = slot_q[i].req.qos;
            cur_age = now_i - slot_q[i].arrival;  // Wrap-safe age
            if (cur_qos.urgent != best_qos.urgent) begin
                better = cur_qos.urgent;
            end else if (cur_qos.level != best_qos.level) begin
                better = cur_qos.level > best_qos.level;
            end else begin
                better = cur_age > best_age;  // Older wins
            end
            if (valid_q[i] && (!sel_valid_o || better)) begin
                sel_valid_o = 1'b1;
                sel_idx     = SLOT_W'(i);
                best_qos    = cur_qos;
                best_age    = cur_age;
            end
        end
        sel_entry_o = slot_q[sel_idx];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            if (deq_i && sel_valid_o) valid_q[sel_idx] <= 1'b0;   // Slot leaves
            if (push_i && free_found) valid_q[free_idx] <= 1'b1;  // Never the same slot
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i && free_found) begin
            slot_q[free_idx] <= '{req: push_req_i, arrival: now_i};
        end
    end

endmodule

// File: hw/qos_tag_array.sv
// ------------------------------
// Tag and data array
// Per way and set: valid, tag, one data word, QoS level
// and last-use stamp; tag compare is combinational
// ------------------------------
module qos_tag_array #(
    parameter  int WAYS  = 2,
    parameter  int SETS  = 8,
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = 30 - IDX_W
) (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic [IDX_W-1:0]                      index_i,
    input  logic [TAG_W-1:0]                      tag_i,
    input  qos_cache_pkg::stamp_t                 now_i,
    input  logic                                  touch_en_i,
    input  logic [WAY_W-1:0]                      touch_way_i,
    input  logic                                  fill_en_i,
    input  logic [WAY_W-1:0]                      fill_way_i,
    input  qos_cache_pkg::word_t                  fill_data_i,
    input  qos_cache_pkg::qos_level_t             fill_level_i,  // Level of current request
    output logic                                  hit_o,
    output logic [WAY_W-1:0]                      hit_way_o,
    output qos_cache_pkg::word_t                  hit_data_o,
    output logic [WAYS-1:0]                       way_valid_o,
    output qos_cache_pkg::qos_level_t [WAYS-1:0]  way_level_o,
    output qos_cache_pkg::stamp_t [WAYS-1:0]      way_stamp_o
);
    logic [WAYS-1:0][SETS-1:0] valid_q;
    logic [TAG_W-1:0]          tag_q   [WAYS][SETS];
    qos_cache_pkg::word_t      data_q  [WAYS][SETS];
    qos_cache_pkg::qos_level_t level_q [WAYS][SETS];
    qos_cache_pkg::stamp_t     stamp_q [WAYS][SETS];

    // Read out the addressed set, first matching way wins
    always_comb begin
        hit_o      = 1'b0;
        hit_way_o  = '0;
        hit_data_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            way_valid_o[w] = valid_q[w][index_i];
            way_level_o[w] = level_q[w][index_i];
            way_stamp_o[w] = stamp_q[w][index_i];
            if (valid_q[w][index_i] && tag_q[w][index_i] == tag_i && !hit_o) begin
                hit_o      = 1'b1;
                hit_way_o  = WAY_W'(w);
                hit_data_o = data_q[w][index_i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (fill_en_i) begin
            valid_q[fill_way_i][index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_en_i) begin
            tag_q[fill_way_i][index_i]   <= tag_i;
            data_q[fill_way_i][index_i]  <= fill_data_i;
            level_q[fill_way_i][index_i] <= fill_level_i;
            stamp_q[fill_way_i][index_i] <= now_i;
        end else if (touch_en_i) begin
            stamp_q[touch_way_i][index_i] <= now_i;  // Most recent use
            // Level only ever rises on reuse
            if (fill_level_i > level_q[touch_way_i][index_i]) begin
                level_q[touch_way_i][index_i] <= fill_level_i;
            end
        end
    end

endmodule

// File: hw/qos_victim_select.sv
// ------------------------------
// Victim way selection
// LRU, QoS-protecting LRU and QoS-priority with bypass
// ------------------------------
module qos_victim_select #(
    parameter  int WAYS  = 2,
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  logic [WAYS-1:0]                      way_valid_i,
    input  qos_cache_pkg::qos_level_t [WAYS-1:0] way_level_i,
    input  qos_cache_pkg::stamp_t [WAYS-1:0]     way_stamp_i,
    input  qos_cache_pkg::stamp_t                now_i,
    input  qos_cache_pkg::qos_level_t            req_level_i,
    input  qos_cache_pkg::repl_policy_e          policy_i,
    output logic [WAY_W-1:0]                     victim_way_o,
    output logic                                 allocate_o  // Low means bypass
);
    logic                  inv_found, qlru_found, low_found;
    logic [WAY_W-1:0]      inv_way, lru_way, qlru_way, low_way;
    qos_cache_pkg::stamp_t lru_age, qlru_age;

    // ------------------------------
    // Candidate scan
    // ------------------------------
    always_comb begin
        qos_cache_pkg::stamp_t age;
        inv_found  = 1'b0;
        qlru_found = 1'b0;
        low_found  = 1'b0;
        inv_way    = '0;
        lru_way    = '0;
        qlru_way   = '0;
        low_way    = '0;
        lru_age    = '0;
        qlru_age   = '0;
        for (int w = 0; w < WAYS; w++) begin
            age = now_i - way_stamp_i[w];
            if (!way_valid_i[w] && !inv_found) begin  // Lowest empty way
                inv_found = 1'b1;
                inv_way   = WAY_W'(w);
            end
            if (w == 0 || age > lru_age) begin        // Oldest overall
                lru_age = age;
                lru_way = WAY_W'(w);
            end
            // Oldest among lines no more important than the request
            if (way_level_i[w] <= req_level_i && (!qlru_found || age > qlru_age)) begin
                qlru_found = 1'b1;
                qlru_age   = age;
                qlru_way   = WAY_W'(w);
            end
            if (way_level_i[w] == 2'd0 && !low_found) begin
                low_found = 1'b1;
                low_way   = WAY_W'(w);
            end
        end
    end

    always_comb begin
        allocate_o   = 1'b1;
        victim_way_o = lru_way;
        if (inv_found) begin
            victim_way_o = inv_way;
        end else begin
            case (policy_i)
                qos_cache_pkg::REPL_QOS_LRU: victim_way_o = qlru_found ? qlru_way : lru_way;
                qos_cache_pkg::REPL_QOS_PRIORITY: begin
                    if (low_found) begin
                        victim_way_o = low_way;
                    end else begin
                        allocate_o = (req_level_i >= 2'd2);  // Low levels bypass
                    end
                end
                default: victim_way_o = lru_way;  // LRU and value 3
            endcase
        end
    end

endmodule

// File: hw/qos_perf_monitor.sv
// ------------------------------
// QoS performance monitor
// Per-level hit and miss counts plus latency violations,
// all saturating
// ------------------------------
module qos_perf_monitor (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        rsp_fire_i,
    input  logic                        rsp_hit_i,
    input  qos_cache_pkg::qos_cfg_t     rsp_qos_i,
    input  qos_cache_pkg::stamp_t       arrival_i,
    input  qos_cache_pkg::stamp_t       now_i,
    output qos_cache_pkg::perf_counts_t counts_o
);
    qos_cache_pkg::perf_counts_t counts_q;
    qos_cache_pkg::stamp_t       latency;
    qos_cache_pkg::qos_level_t   lvl;

    function automatic qos_cache_pkg::count_t sat_inc(input qos_cache_pkg::count_t c);
        return (c == '1) ? c : c + 1'b1;  // Hold at max
    endfunction

    assign latency = now_i - arrival_i;  // Queue wait included
    assign lvl     = rsp_qos_i.level;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            counts_q <= '0;
        end else if (rsp_fire_i) begin
            if (rsp_hit_i) begin
                counts_q.hits[lvl] <= sat_inc(counts_q.hits[lvl]);
            end else begin
                counts_q.misses[lvl] <= sat_inc(counts_q.misses[lvl]);
            end
            if (latency > rsp_qos_i.max_latency) begin
                counts_q.violations <= sat_inc(counts_q.violations);
            end
        end
    end

    assign counts_o = counts_q;

endmodule

// File: hw/qos_cache_ctrl.sv
// ------------------------------
// Cache control FSM
// Dequeue, lookup, miss request, fill and response;
// owns the cycle timer and the memory credit count
// ------------------------------
module qos_cache_ctrl #(
    parameter  int WAYS  = 2,
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        sel_valid_i,
    input  qos_cache_pkg::queue_entry_t sel_entry_i,
    output logic                        deq_o,
    input  logic                        hit_i,
    input  logic [WAY_W-1:0]            hit_way_i,
    input  qos_cache_pkg::word_t        hit_data_i,
    input  logic [WAY_W-1:0]            victim_way_i,
    input  logic                        allocate_i,
    output logic                        touch_en_o,
    output logic [WAY_W-1:0]            touch_way_o,
    output logic                        fill_en_o,
    output logic [WAY_W-1:0]            fill_way_o,
    output qos_cache_pkg::word_t        fill_data_o,
    output qos_cache_pkg::cache_req_t   lookup_req_o,
    input  logic                        mem_credit_i,
    output logic                        mem_req_valid_o,
    output qos_cache_pkg::addr_t        mem_addr_o,
    input  logic                        mem_rsp_valid_i,
    input  qos_cache_pkg::word_t        mem_rsp_data_i,
    output logic                        rsp_valid_o,
    output qos_cache_pkg::cache_rsp_t   rsp_o,
    output qos_cache_pkg::stamp_t       arrival_o,
    output qos_cache_pkg::stamp_t       now_o
);
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        RESPOND
    } state_e;

    state_e                      state_q, state_d;
    qos_cache_pkg::queue_entry_t entry_q;     // Request in flight
    qos_cache_pkg::word_t        data_q;
    logic                        hit_q;
    qos_cache_pkg::stamp_t       now_q;       // Free-running
    logic [7:0]                  mem_cred_q;  // Credits granted by memory

    // ------------------------------
    // Next state and strobes
    // ------------------------------
    always_comb begin
        state_d         = state_q;
        deq_o           = 1'b0;
        touch_en_o      = 1'b0;
        fill_en_o       = 1'b0;
        mem_req_valid_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (sel_valid_i) begin
                    deq_o   = 1'b1;  // Also returns a requester credit
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                touch_en_o = hit_i;
                state_d    = hit_i ? RESPOND : MISS_REQ;
            end
            MISS_REQ: begin
                if (mem_cred_q != '0) begin  // Stall here without credit
                    mem_req_valid_o = 1'b1;
                    state_d         = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (mem_rsp_valid_i) begin
                    fill_en_o = allocate_i;  // Bypass leaves the set alone
                    state_d   = RESPOND;
                end
            end
            default: state_d = IDLE;  // RESPOND lasts one cycle
        endcase
    end

    assign touch_way_o  = hit_way_i;
    assign fill_way_o   = victim_way_i;
    assign fill_data_o  = mem_rsp_data_i;
    assign lookup_req_o = entry_q.req;       // Held steady through the fill
    assign mem_addr_o   = entry_q.req.addr;
    assign rsp_valid_o  = (state_q == RESPOND);
    assign rsp_o        = '{data: data_q, hit: hit_q, qos: entry_q.req.qos};
    assign arrival_o    = entry_q.arrival;
    assign now_o        = now_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            now_q      <= '0;
            mem_cred_q <= '0;
        end else begin
            state_q    <= state_d;
            now_q      <= now_q + 1'b1;
            mem_cred_q <= mem_cred_q + 8'(mem_credit_i) - 8'(mem_req_valid_o);
        end
    end

    // Payload capture
    always_ff @(posedge clk_i) begin
        if (deq_o) entry_q <= sel_entry_i;
        if (state_q == LOOKUP && hit_i) begin
            data_q <= hit_data_i;
            hit_q  <= 1'b1;
        end
        if (state_q == MISS_WAIT && mem_rsp_valid_i) begin
            data_q <= mem_rsp_data_i;
            hit_q  <= 1'b0;
        end
    end

endmodule

// File: hw/qos_cache_top.sv
// ------------------------------
// QoS-aware read-only cache, top level
// Credit-based requester and memory ports around the
// queue, tag array, victim select, monitor and FSM
// ------------------------------
module qos_cache_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int WAYS        = 2,
    parameter int SETS        = 8
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        req_valid_i,
    input  qos_cache_pkg::cache_req_t   req_i,
    output logic                        req_credit_o,
    output logic                        rsp_valid_o,
    output qos_cache_pkg::cache_rsp_t   rsp_o,
    input  logic                        mem_credit_i,
    output logic                        mem_req_valid_o,
    output qos_cache_pkg::addr_t        mem_addr_o,
    input  logic                        mem_rsp_valid_i,
    input  qos_cache_pkg::word_t        mem_rsp_data_i,
    input  qos_cache_pkg::repl_policy_e policy_i,
    output qos_cache_pkg::perf_counts_t counts_o
);
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 30 - IDX_W;

    logic                                sel_valid, deq;
    qos_cache_pkg::queue_entry_t         sel_entry;
    qos_cache_pkg::cache_req_t           lookup_req;
    logic [IDX_W-1:0]                    lookup_index;
    logic [TAG_W-1:0]                    lookup_tag;
    qos_cache_pkg::stamp_t               now, arrival;
    logic                                hit, allocate, touch_en, fill_en;
    logic [WAY_W-1:0]                    hit_way, victim_way, touch_way, fill_way;
    qos_cache_pkg::word_t                hit_data, fill_data;
    logic [WAYS-1:0]                     way_valid;
    qos_cache_pkg::qos_level_t [WAYS-1:0] way_level;
    qos_cache_pkg::stamp_t [WAYS-1:0]    way_stamp;

    // Index sits just above the byte offset
    assign lookup_index = lookup_req.addr[IDX_W+1:2];
    assign lookup_tag   = lookup_req.addr[31:IDX_W+2];
    assign req_credit_o = deq;  // One credit per removed entry

    qos_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) qos_req_queue_inst (
        .clk_i, .rst_ni,
        .push_i(req_valid_i), .push_req_i(req_i), .now_i(now), .deq_i(deq),
        .sel_valid_o(sel_valid), .sel_entry_o(sel_entry)
    );

    qos_tag_array #(.WAYS(WAYS), .SETS(SETS)) qos_tag_array_inst (
        .clk_i, .rst_ni,
        .index_i(lookup_index), .tag_i(lookup_tag), .now_i(now),
        .touch_en_i(touch_en), .touch_way_i(touch_way),
        .fill_en_i(fill_en), .fill_way_i(fill_way), .fill_data_i(fill_data),
        .fill_level_i(lookup_req.qos.level),
        .hit_o(hit), .hit_way_o(hit_way), .hit_data_o(hit_data),
        .way_valid_o(way_valid), .way_level_o(way_level), .way_stamp_o(way_stamp)
    );

    qos_victim_select #(.WAYS(WAYS)) qos_victim_select_inst (
        .way_valid_i(way_valid), .way_level_i(way_level), .way_stamp_i(way_stamp),
        .now_i(now), .req_level_i(lookup_req.qos.level), .policy_i,
        .victim_way_o(victim_way), .allocate_o(allocate)
    );

    qos_perf_monitor qos_perf_monitor_inst (
        .clk_i, .rst_ni,
        .rsp_fire_i(rsp_valid_o), .rsp_hit_i(rsp_o.hit), .rsp_qos_i(rsp_o.qos),
        .arrival_i(arrival), .now_i(now), .counts_o
    );

    qos_cache_ctrl #(.WAYS(WAYS)) qos_cache_ctrl_inst (
        .clk_i, .rst_ni,
        .sel_valid_i(sel_valid), .sel_entry_i(sel_entry), .deq_o(deq),
        .hit_i(hit), .hit_way_i(hit_way), .hit_data_i(hit_data),
        .victim_way_i(victim_way), .allocate_i(allocate),
        .touch_en_o(touch_en), .touch_way_o(touch_way),
        .fill_en_o(fill_en), .fill_way_o(fill_way), .fill_data_o(fill_data),
        .lookup_req_o(lookup_req),
        .mem_credit_i, .mem_req_valid_o, .mem_addr_o, .mem_rsp_valid_i, .mem_rsp_data_i,
        .rsp_valid_o, .rsp_o, .arrival_o(arrival), .now_o(now)
    );

endmodule

// File: tests/qos_cache_chk.sv
// ------------------------------
// QoS cache protocol checker
// Credit and response rules, bound to the top level
// ------------------------------
module qos_cache_chk #(
    parameter int QUEUE_DEPTH = 4
) (
    input logic clk_i,
    input logic rst_ni,
    input logic req_valid_i,
    input logic req_credit_o,
    input logic rsp_valid_o,
    input logic mem_credit_i,
    input logic mem_req_valid_o
);
    int req_cred;  // Credits held by the requester
    int mem_cred;  // Credits held by the cache

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_cred <= QUEUE_DEPTH;
            mem_cred <= 0;
        end else begin
            req_cred <= req_cred + int'(req_credit_o) - int'(req_valid_i);
            mem_cred <= mem_cred + int'(mem_credit_i) - int'(mem_req_valid_o);
        end
    end

    req_credit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> req_cred > 0)
        else $error("request accepted with no requester credit");

    mem_credit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o |-> mem_cred > 0)
        else $error("memory request issued with no memory credit");

    rsp_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_o |=> !rsp_valid_o)
        else $error("response valid held longer than one cycle");

endmodule

bind qos_cache_top qos_cache_chk #(.QUEUE_DEPTH(QUEUE_DEPTH)) qos_cache_chk_inst (.*);

// File: tests/qos_cache_tb.sv
// ------------------------------
// QoS cache testbench
// Credit-tracking requester, in-order memory model and
// directed tests for hits, priority, policies, counters
// ------------------------------
module qos_cache_tb;
    localparam int          QUEUE_DEPTH = 4;
    localparam int          MAX_CYCLES  = 4000;          // About 600 cycles of tests
    localparam logic [31:0] MEM_OFFSET  = 32'h1000_0000; // Memory returns addr plus this

    logic                        clk_i, rst_ni, req_valid_i, req_credit_o, rsp_valid_o;
    logic                        mem_credit_i, mem_req_valid_o, mem_rsp_valid_i;
    qos_cache_pkg::cache_req_t   req_i;
    qos_cache_pkg::cache_rsp_t   rsp_o;
    qos_cache_pkg::addr_t        mem_addr_o;
    qos_cache_pkg::word_t        mem_rsp_data_i;
    qos_cache_pkg::repl_policy_e policy_i;
    qos_cache_pkg::perf_counts_t counts_o;

    int  cycles, errors, test_errors, spent, returned, mem_granted, mem_used;
    int  exp_hits [4];
    int  exp_misses [4];
    int  exp_viol;
    bit  mem_auto;                          // Memory grants credits on its own
    qos_cache_pkg::cache_rsp_t rsp_q [$];   // Responses seen by the requester
    qos_cache_pkg::addr_t      mem_q [$];   // Memory requests in flight

    qos_cache_top qos_cache_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Watchdog
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: no progress after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // Requester side monitor, credits and responses taken at the clock edge
    always @(posedge clk_i) begin
        if (rst_ni && req_credit_o) returned++;
        if (rst_ni && rsp_valid_o) rsp_q.push_back(rsp_o);
    end

    // ------------------------------
    // Memory model
    // ------------------------------
    initial begin
        mem_rsp_valid_i = 1'b0;
        mem_credit_i    = 1'b0;
        mem_rsp_data_i  = '0;
        forever begin
            @(negedge clk_i);
            mem_rsp_valid_i = 1'b0;
            mem_credit_i    = 1'b0;
            if (rst_ni && mem_q.size() > 0) begin  // Answer one cycle later, in order
                mem_rsp_data_i  = mem_q.pop_front() + MEM_OFFSET;
                mem_rsp_valid_i = 1'b1;
            end
            if (rst_ni && mem_req_valid_o) begin
                mem_q.push_back(mem_addr_o);
                mem_used++;
            end
            if (rst_ni && mem_auto && mem_granted - mem_used < 2) begin  // Keep two spare
                mem_credit_i = 1'b1;
                mem_granted++;
            end
        end
    end

    function automatic int credits();
        return QUEUE_DEPTH - spent + returned;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("error %s: expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic send_req(input logic [31:0] addr, input logic [1:0] level,
                            input logic urgent, input logic [7:0] max_lat);
        while (credits() == 0) @(negedge clk_i);  // Only with a credit in hand
        req_i       = '{addr: addr, qos: '{level: level, urgent: urgent, max_latency: max_lat}};
        req_valid_i = 1'b1;
        spent++;
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic get_rsp(output qos_cache_pkg::cache_rsp_t r);
        while (rsp_q.size() == 0) @(negedge clk_i);
        r = rsp_q.pop_front();
    endtask

    // Expected response bookkeeping shared by all tests
    task automatic expect_rsp(input string name, input qos_cache_pkg::cache_rsp_t r,
                              input logic [31:0] addr, input logic [1:0] level,
                              input logic urgent, input logic hit, input logic [7:0] max_lat);
        check_val({name, " data"}, addr + MEM_OFFSET, r.data);
        check_val({name, " hit"}, hit, r.hit);
        check_val({name, " qos"}, {level, urgent, max_lat}, r.qos);  // Echo of the request
        if (hit) exp_hits[level]++;
        else exp_misses[level]++;
        if (max_lat == 8'd0) exp_viol++;  // Any real latency exceeds zero
    endtask

    task automatic access(input string name, input logic [31:0] addr, input logic [1:0] level,
                          input logic hit, input logic [7:0] max_lat);
        qos_cache_pkg::cache_rsp_t r;
        send_req(addr, level, 1'b0, max_lat);
        get_rsp(r);
        expect_rsp(name, r, addr, level, 1'b0, hit, max_lat);
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_hit_miss();
        mem_auto = 1'b1;
        access("hit_miss cold", 32'h0000_0100, 2'd1, 1'b0, 8'd255);
        access("hit_miss repeat", 32'h0000_0100, 2'd1, 1'b1, 8'd255);
        end_test("hit_miss");
    endtask

    task automatic test_priority();
        logic [31:0] exp_addr [5] = '{32'h1010, 32'h5010, 32'h3010, 32'h4010, 32'h2010};
        logic [1:0]  exp_lvl [5]  = '{2'd0, 2'd0, 2'd3, 2'd1, 2'd0};
        logic        exp_urg [5]  = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
        qos_cache_pkg::cache_rsp_t r;
        mem_auto = 1'b0;
        // Spend the spare memory credits so the next miss has none
        for (int i = 0; mem_granted - mem_used > 0; i++) begin
            access("priority drain", 32'h7010 + 32'(i) * 32'h1000, 2'd0, 1'b0, 8'd255);
        end
        send_req(32'h1010, 2'd0, 1'b0, 8'd255);  // Dequeued at once, stalls in MISS_REQ
        while (credits() < QUEUE_DEPTH) @(negedge clk_i);
        send_req(32'h2010, 2'd0, 1'b0, 8'd255);
        send_req(32'h3010, 2'd3, 1'b0, 8'd255);
        send_req(32'h4010, 2'd1, 1'b0, 8'd255);
        send_req(32'h5010, 2'd0, 1'b1, 8'd255);  // Urgent beats level
        repeat (4) @(negedge clk_i);
        check_val("priority stall", 0, rsp_q.size());  // Nothing answers without credit
        mem_auto = 1'b1;
        for (int i = 0; i < 5; i++) begin
            get_rsp(r);
            expect_rsp("priority", r, exp_addr[i], exp_lvl[i], exp_urg[i], 1'b0, 8'd255);
        end
        @(negedge clk_i);
        check_val("priority credits", QUEUE_DEPTH, credits());
        end_test("priority");
    endtask

    task automatic test_policies();
        policy_i = qos_cache_pkg::REPL_LRU;           // Set 1, oldest line goes
        access("lru fill a", 32'h104, 2'd3, 1'b0, 8'd255);
        access("lru fill b", 32'h204, 2'd0, 1'b0, 8'd255);
        access("lru fill c", 32'h304, 2'd0, 1'b0, 8'd255);
        access("lru probe a", 32'h104, 2'd3, 1'b0, 8'd255);
        policy_i = qos_cache_pkg::REPL_QOS_LRU;       // Set 2, level 3 line protected
        access("qlru fill a", 32'h108, 2'd3, 1'b0, 8'd255);
        access("qlru fill b", 32'h208, 2'd0, 1'b0, 8'd255);
        access("qlru fill c", 32'h308, 2'd0, 1'b0, 8'd255);
        access("qlru probe a", 32'h108, 2'd3, 1'b1, 8'd255);
        policy_i = qos_cache_pkg::REPL_QOS_PRIORITY;  // Set 3, level 1 miss is bypassed
        access("prio fill a", 32'h10C, 2'd1, 1'b0, 8'd255);
        access("prio fill b", 32'h20C, 2'd1, 1'b0, 8'd255);
        access("prio bypass c", 32'h30C, 2'd1, 1'b0, 8'd255);
        access("prio probe c", 32'h30C, 2'd1, 1'b0, 8'd255);
        access("prio probe a", 32'h10C, 2'd1, 1'b1, 8'd255);
        end_test("policies");
    endtask

    task automatic test_counters();
        policy_i = qos_cache_pkg::REPL_LRU;
        access("viol hit", 32'h0000_0100, 2'd1, 1'b1, 8'd0);
        access("viol miss", 32'h6010, 2'd2, 1'b0, 8'd0);
        @(negedge clk_i);  // Monitor counts on the edge after the response
        for (int l = 0; l < 4; l++) begin
            check_val("counters hits", exp_hits[l], counts_o.hits[l]);
            check_val("counters misses", exp_misses[l], counts_o.misses[l]);
        end
        check_val("counters violations", exp_viol, counts_o.violations);
        end_test("counters");
    endtask

    task automatic test_random();
        bit          seen [6];
        int          k;
        logic [1:0]  level;
        logic [31:0] addr;
        // Sets 5 to 7 with two tags each never evict
        for (int i = 0; i < 40; i++) begin
            k     = $urandom_range(5, 0);
            level = 2'($urandom_range(3, 0));
            addr  = (32'(k / 3 + 1) << 8) | (32'(5 + k % 3) << 2);
            access("random", addr, level, seen[k], 8'd255);
            seen[k] = 1'b1;
        end
        @(negedge clk_i);
        check_val("random credits", QUEUE_DEPTH, credits());
        end_test("random");
    endtask

    initial begin
        void'($urandom(40768));
        rst_ni      = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        policy_i    = qos_cache_pkg::REPL_LRU;
        mem_auto    = 1'b0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        test_hit_miss();
        test_priority();
        test_policies();
        test_counters();
        test_random();
        $display("Summary: 5 tests, %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: all.f
hw/qos_cache_pkg.sv
hw/qos_req_queue.sv
hw/qos_tag_array.sv
hw/qos_victim_select.sv
hw/qos_perf_monitor.sv
hw/qos_cache_ctrl.sv
hw/qos_cache_top.sv
tests/qos_cache_chk.sv
tests/qos_cache_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module qos_cache_tb -f all.f -o Vqos_cache_tb

run: build
	./obj_dir/Vqos_cache_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module qos_cache_tb -f all.f

clean:
	rm -rf obj_dir sim.log
